// File: sim/fmb_patterns.txt
# name bp lockdrop fault0 fault1 flipbit | exp_fail exp_chan exp_addr(hex) exp_bank exp_total
# fault index is the word number in the window, -1 for no fault on that channel
clean          0 0 -1 -1  0  0 0 000000000 0 0
ch1_fault      0 0 -1  3  5  1 1 00000500c 5 1
dual_fault     0 0  7  2 17  1 0 00000201c 2 2
lock_drop      0 1 -1 -1  0  0 0 000000000 0 0
bp_clean       1 0 -1 -1  0  0 0 000000000 0 0
bp_ch1_fault   1 0 -1 12 63  1 1 000005030 5 1
bp_dual_fault  1 1  0 15 40  1 0 000002000 2 2

// File: flist.f
+incdir+include
hw/fmb_pkg.sv
hw/chk_status_if.sv
hw/ddr_reset_sequencer.sv
hw/memory_checker.sv
hw/test_status_combiner.sv
hw/fmb_tester_top.sv
sim/fmb_tester_props.sv
sim/tb_fmb_tester.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fmb_tester -f flist.f -o sim_fmb

output="$(./obj_dir/sim_fmb 2>&1)" || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

// File: sim/tb_fmb_tester.sv
// Run from the project root so sim/fmb_patterns.txt resolves; one test per pattern line
`default_nettype none
`timescale 1ns/1ps
`include "fmb_defines.svh"

module tb_fmb_tester;

	localparam int RQ_DEPTH = 8;
	localparam int MAX_TESTS = 16;

	logic iACLK;
	logic qARST;
	logic pll_locked;
	logic cfg_done;
	logic cfg_reset;
	logic cfg_start;
	logic axi_rstn;
	// Memory side signals indexed by channel
	logic [1:0]                        cmd_valid;
	logic [1:0]                        cmd_we;
	logic [1:0][`FMB_ADDR_W-1:0]       cmd_addr;
	logic [1:0][`FMB_DATA_W-1:0]       wdata;
	logic [1:0]                        mem_ready;
	logic [1:0]                        mem_rvalid;
	logic [1:0][`FMB_DATA_W-1:0]       mem_rdata;
	logic                              test_run;
	logic                              test_done;
	logic                              test_fail;
	logic                              fail_chan;
	logic [`FMB_ADDR_W-1:0]            fail_addr;
	logic [2:0]                        fail_bank;
	logic [5:0]                        err_total;

	// Pattern table
	string                  t_name [0:MAX_TESTS-1];
	int                     t_bp [0:MAX_TESTS-1];
	int                     t_lock [0:MAX_TESTS-1];
	int                     t_f0 [0:MAX_TESTS-1];
	int                     t_f1 [0:MAX_TESTS-1];
	int                     t_bit [0:MAX_TESTS-1];
	int                     t_fail [0:MAX_TESTS-1];
	int                     t_chan [0:MAX_TESTS-1];
	logic [`FMB_ADDR_W-1:0] t_addr [0:MAX_TESTS-1];
	int                     t_bank [0:MAX_TESTS-1];
	int                     t_total [0:MAX_TESTS-1];
	int                     n_tests;

	// Current test
	string cur_name;
	int    cur_bp;
	int    cur_lock;
	int    cur_f0;
	int    cur_f1;
	int    cur_bit;
	int    test_errs;
	int    pass_cnt;
	int    fail_cnt;
	int    total_errs;

	// Memory models
	logic [`FMB_DATA_W-1:0] mem [0:1][0:`FMB_CHK_WORDS-1];
	logic [`FMB_ADDR_W-1:0] rq_addr [0:1][0:RQ_DEPTH-1];
	int                     rq_dly [0:1][0:RQ_DEPTH-1];
	// Tick at which the queue head may return
	int                     head_due [0:1];
	int                     rq_head [0:1];
	int                     rq_cnt [0:1];
	int                     wr_cnt [0:1];
	int                     rd_cnt [0:1];
	logic [31:0]            rng;

	// Sequencer watch
	int   ticks;
	int   cycles = 0;
	int   cycle_limit;
	int   run_len;
	int   start_len;
	int   drop_left;
	logic drop_done;
	logic run_seen;
	logic prev_cfg_reset;
	logic prev_axi_rstn;

	fmb_tester_top UUT
	(
		.iACLK          (iACLK),
		.qARST          (qARST),
		.i_pll_locked   (pll_locked),
		.i_cfg_done     (cfg_done),
		.o_cfg_reset    (cfg_reset),
		.o_cfg_start    (cfg_start),
		.o_axi_rstn     (axi_rstn),
		.o_m0_cmd_valid (cmd_valid[0]),
		.i_m0_cmd_ready (mem_ready[0]),
		.o_m0_cmd_we    (cmd_we[0]),
		.o_m0_cmd_addr  (cmd_addr[0]),
		.o_m0_wdata     (wdata[0]),
		.i_m0_rvalid    (mem_rvalid[0]),
		.i_m0_rdata     (mem_rdata[0]),
		.o_m1_cmd_valid (cmd_valid[1]),
		.i_m1_cmd_ready (mem_ready[1]),
		.o_m1_cmd_we    (cmd_we[1]),
		.o_m1_cmd_addr  (cmd_addr[1]),
		.o_m1_wdata     (wdata[1]),
		.i_m1_rvalid    (mem_rvalid[1]),
		.i_m1_rdata     (mem_rdata[1]),
		.o_test_run     (test_run),
		.o_test_done    (test_done),
		.o_test_fail    (test_fail),
		.o_fail_chan    (fail_chan),
		.o_fail_addr    (fail_addr),
		.o_fail_bank    (fail_bank),
		.o_err_total    (err_total)
	);

	// 8 ns clock
	always #4 iACLK = ~iACLK;

	// --------------------
	// Run limit
	always @(posedge iACLK)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout: %0d cycles passed and the tests did not finish", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Flat address widened and XORed with the seed in both halves
	function automatic logic [63:0] expected_word(input logic [32:0] addr,
		input logic [31:0] seed);
		return 64'(addr) ^ {seed, seed};
	endfunction

	task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act)
		begin
			$display("** Error: %s %s: expected %h, actual %h", cur_name, what, exp, act);
			test_errs++;
		end
	endtask

	// --------------------
	// Pattern file
	task automatic load_patterns();
		int    fd;
		int    cnt;
		string line;
		string nm;
		int    v[0:8];
		logic [`FMB_ADDR_W-1:0] a;
		n_tests = 0;
		fd = $fopen("sim/fmb_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Error: could not open sim/fmb_patterns.txt");
			return;
		end
		while (!$feof(fd) && n_tests < MAX_TESTS)
		begin
			line = "";
			cnt = $fgets(line, fd);
			// Comments and blank lines skipped
			if (cnt > 0 && line.getc(0) != "#")
			begin
				cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %h %d %d", nm, v[0], v[1], v[2],
					v[3], v[4], v[5], v[6], a, v[7], v[8]);
				if (cnt == 11)
				begin
					t_name[n_tests]  = nm;
					t_bp[n_tests]    = v[0];
					t_lock[n_tests]  = v[1];
					t_f0[n_tests]    = v[2];
					t_f1[n_tests]    = v[3];
					t_bit[n_tests]   = v[4];
					t_fail[n_tests]  = v[5];
					t_chan[n_tests]  = v[6];
					t_addr[n_tests]  = a;
					t_bank[n_tests]  = v[7];
					t_total[n_tests] = v[8];
					n_tests++;
				end
			end
		end
		$fclose(fd);
	endtask

	// --------------------
	// Sequencer watch and drive
	task automatic watch_sequencer();
		// Last edge saw the held inputs and the state of one tick ago
		if (!qARST && pll_locked && prev_cfg_reset)
			run_len++;
		else if (qARST || !pll_locked)
			run_len = 0;
		if (prev_cfg_reset && !cfg_reset)
			compare("locked cycles in cfg reset", 64'(`FMB_CFG_RST_CYCLES), 64'(run_len));
		compare("cfg_start during cfg_reset", 64'(0), 64'(cfg_start & cfg_reset));
		if (!prev_axi_rstn && axi_rstn)
			compare("cfg_done before axi_rstn", 64'(1), 64'(cfg_done));
		if (test_run)
			run_seen = 1'b1;
		// Controller answers start after 3 cycles
		if (cfg_start)
			start_len++;
		if (start_len >= 3)
			cfg_done = 1'b1;
		// Lock lost halfway through the config reset
		if (cur_lock != 0 && !drop_done && run_len == 8)
		begin
			pll_locked = 1'b0;
			drop_left  = 3;
			drop_done  = 1'b1;
		end
		else if (drop_left > 0)
		begin
			drop_left--;
			if (drop_left == 0)
				pll_locked = 1'b1;
		end
		prev_cfg_reset = cfg_reset;
		prev_axi_rstn  = axi_rstn;
	endtask

	// --------------------
	// One memory port decided for the next rising edge
	task automatic serve_channel(input int ch);
		logic [`FMB_ADDR_W-1:0] base;
		logic [31:0]            seed;
		logic [`FMB_ADDR_W-1:0] exp_a;
		logic [`FMB_ADDR_W-1:0] off;
		logic [`FMB_DATA_W-1:0] d;
		int                     idx;
		int                     fault;
		int                     tail;
		base  = (ch == 0) ? `FMB_CH0_BASE : `FMB_CH1_BASE;
		seed  = (ch == 0) ? 32'h5a5a0f0f : 32'ha5a5f0f0;
		fault = (ch == 0) ? cur_f0 : cur_f1;

		// Oldest read returns first
		// Its delay runs from the moment it heads the queue
		mem_rvalid[ch] = 1'b0;
		if (rq_cnt[ch] > 0 && ticks >= head_due[ch])
		begin
			off = rq_addr[ch][rq_head[ch]] - base;
			d   = '0;
			if (off < `FMB_ADDR_W'(`FMB_CHK_WORDS * `FMB_ADDR_STEP))
			begin
				idx = int'(off) / `FMB_ADDR_STEP;
				d   = mem[ch][idx];
				if (idx == fault)
					d[cur_bit] = ~d[cur_bit];
			end
			mem_rdata[ch]  = d;
			mem_rvalid[ch] = 1'b1;
			rq_head[ch]    = (rq_head[ch] + 1) % RQ_DEPTH;
			rq_cnt[ch]--;
			if (rq_cnt[ch] > 0)
				head_due[ch] = ticks + rq_dly[ch][rq_head[ch]];
		end

		if (cur_bp != 0)
		begin
			rng = xorshift(rng);
			mem_ready[ch] = rng[0];
		end
		else
			mem_ready[ch] = 1'b1;

		if (cmd_valid[ch] && mem_ready[ch] && !qARST)
		begin
			if (cmd_we[ch])
			begin
				exp_a = base + `FMB_ADDR_W'(wr_cnt[ch] * `FMB_ADDR_STEP);
				compare($sformatf("ch%0d write %0d addr", ch, wr_cnt[ch]), 64'(exp_a),
					64'(cmd_addr[ch]));
				compare($sformatf("ch%0d write %0d data", ch, wr_cnt[ch]),
					expected_word(exp_a, seed), wdata[ch]);
				if (wr_cnt[ch] < `FMB_CHK_WORDS)
					mem[ch][wr_cnt[ch]] = wdata[ch];
				wr_cnt[ch]++;
			end
			else
			begin
				exp_a = base + `FMB_ADDR_W'(rd_cnt[ch] * `FMB_ADDR_STEP);
				compare($sformatf("ch%0d read %0d addr", ch, rd_cnt[ch]), 64'(exp_a),
					64'(cmd_addr[ch]));
				tail = (rq_head[ch] + rq_cnt[ch]) % RQ_DEPTH;
				rq_addr[ch][tail] = cmd_addr[ch];
				// 1 to 4 cycles under back-pressure
				rq_dly[ch][tail]  = (cur_bp != 0) ? 1 + int'(rng[3:2]) : 1;
				if (rq_cnt[ch] == 0)
					head_due[ch] = ticks + rq_dly[ch][tail];
				rq_cnt[ch]++;
				rd_cnt[ch]++;
				if (rq_cnt[ch] > `FMB_MAX_RD_INFLIGHT)
				begin
					$display("Error: %s channel %0d has %0d reads outstanding, limit is %0d",
						cur_name, ch, rq_cnt[ch], `FMB_MAX_RD_INFLIGHT);
					test_errs++;
				end
			end
		end
	endtask

	task automatic tick();
		@(negedge iACLK);
		ticks++;
		watch_sequencer();
		serve_channel(0);
		serve_channel(1);
	endtask

	// --------------------
	// One pattern line
	task automatic run_test(input int t);
		cur_name  = t_name[t];
		cur_bp    = t_bp[t];
		cur_lock  = t_lock[t];
		cur_f0    = t_f0[t];
		cur_f1    = t_f1[t];
		cur_bit   = t_bit[t];
		test_errs = 0;
		for (int ch = 0; ch < 2; ch++)
		begin
			rq_head[ch]  = 0;
			rq_cnt[ch]   = 0;
			head_due[ch] = 0;
			wr_cnt[ch]   = 0;
			rd_cnt[ch]   = 0;
		end
		run_len        = 0;
		start_len      = 0;
		drop_left      = 0;
		drop_done      = 1'b0;
		run_seen       = 1'b0;
		prev_cfg_reset = 1'b1;
		prev_axi_rstn  = 1'b0;
		qARST          = 1'b1;
		pll_locked     = 1'b1;
		cfg_done       = 1'b0;
		mem_ready      = '0;
		mem_rvalid     = '0;
		repeat (8)
			tick();
		qARST = 1'b0;
		while (!test_done)
			tick();

		compare("o_test_fail", 64'(t_fail[t]), 64'(test_fail));
		compare("o_fail_chan", 64'(t_chan[t]), 64'(fail_chan));
		compare("o_fail_addr", 64'(t_addr[t]), 64'(fail_addr));
		compare("o_fail_bank", 64'(t_bank[t]), 64'(fail_bank));
		compare("o_err_total", 64'(t_total[t]), 64'(err_total));
		compare("run seen", 64'(1), 64'(run_seen));
		compare("lock dropped", 64'(cur_lock != 0), 64'(drop_done));
		for (int ch = 0; ch < 2; ch++)
		begin
			compare($sformatf("ch%0d writes", ch), 64'(`FMB_CHK_WORDS), 64'(wr_cnt[ch]));
			compare($sformatf("ch%0d reads", ch), 64'(`FMB_CHK_WORDS), 64'(rd_cnt[ch]));
			compare($sformatf("ch%0d reads pending", ch), 64'(0), 64'(rq_cnt[ch]));
		end

		total_errs += test_errs;
		if (test_errs == 0)
		begin
			pass_cnt++;
			$display("test %s passed", cur_name);
		end
		else
		begin
			fail_cnt++;
			$display("test %s failed with %0d errors", cur_name, test_errs);
		end
	endtask

	initial
	begin
		iACLK       = 1'b0;
		qARST       = 1'b1;
		pll_locked  = 1'b0;
		cfg_done    = 1'b0;
		mem_ready   = '0;
		mem_rvalid  = '0;
		mem_rdata   = '0;
		rng         = 32'hafdc;
		ticks       = 0;
		cycle_limit = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		total_errs  = 0;
		cur_name    = "setup";
		load_patterns();
		if (n_tests == 0)
			$display("Error: no tests were read from the pattern file");
		cycle_limit = n_tests * (8 + `FMB_CFG_RST_CYCLES + 20 + 2 * `FMB_CHK_WORDS * 6) * 2;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("%0d tests: %0d passed, %0d failed, %0d errors", n_tests, pass_cnt,
			fail_cnt, total_errs);
		if (n_tests > 0 && fail_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/fmb_tester_props.sv
// Single iACLK domain; every property is held off while qARST is high
`default_nettype none
`timescale 1ns/1ps
`include "fmb_defines.svh"

module fmb_tester_props
(
	input logic                   iACLK,
	input logic                   qARST,
	input logic                   i_cfg_done,
	input logic                   o_axi_rstn,
	input logic                   o_m0_cmd_valid,
	input logic                   i_m0_cmd_ready,
	input logic                   o_m0_cmd_we,
	input logic [`FMB_ADDR_W-1:0] o_m0_cmd_addr,
	input logic [`FMB_DATA_W-1:0] o_m0_wdata,
	input logic                   o_m1_cmd_valid,
	input logic                   i_m1_cmd_ready,
	input logic                   o_m1_cmd_we,
	input logic [`FMB_ADDR_W-1:0] o_m1_cmd_addr,
	input logic [`FMB_DATA_W-1:0] o_m1_wdata,
	input logic                   o_test_done,
	input logic                   o_test_fail
);

	// --------------------
	// Stalled command holds
	a_m0_hold: assert property (@(posedge iACLK) disable iff (qARST)
		(o_m0_cmd_valid && !i_m0_cmd_ready) |=> (o_m0_cmd_valid && $stable(o_m0_cmd_we)
		&& $stable(o_m0_cmd_addr) && $stable(o_m0_wdata)))
	else
		$error("channel 0 command changed under back-pressure");

	a_m1_hold: assert property (@(posedge iACLK) disable iff (qARST)
		(o_m1_cmd_valid && !i_m1_cmd_ready) |=> (o_m1_cmd_valid && $stable(o_m1_cmd_we)
		&& $stable(o_m1_cmd_addr) && $stable(o_m1_wdata)))
	else
		$error("channel 1 command changed under back-pressure");

	// --------------------
	// Port release follows config done
	a_rstn_order: assert property (@(posedge iACLK) disable iff (qARST)
		$rose(o_axi_rstn) |-> $past(i_cfg_done))
	else
		$error("o_axi_rstn rose without i_cfg_done");

	// Fail is a final verdict
	a_fail_done: assert property (@(posedge iACLK) disable iff (qARST)
		o_test_fail |-> o_test_done)
	else
		$error("o_test_fail high before o_test_done");

	// No traffic while ports held in reset
	a_quiet: assert property (@(posedge iACLK) disable iff (qARST)
		!o_axi_rstn |-> !(o_m0_cmd_valid || o_m1_cmd_valid))
	else
		$error("command issued while o_axi_rstn low");

endmodule

bind fmb_tester_top fmb_tester_props u_props
(
	.iACLK          (iACLK),
	.qARST          (qARST),
	.i_cfg_done     (i_cfg_done),
	.o_axi_rstn     (o_axi_rstn),
	.o_m0_cmd_valid (o_m0_cmd_valid),
	.i_m0_cmd_ready (i_m0_cmd_ready),
	.o_m0_cmd_we    (o_m0_cmd_we),
	.o_m0_cmd_addr  (o_m0_cmd_addr),
	.o_m0_wdata     (o_m0_wdata),
	.o_m1_cmd_valid (o_m1_cmd_valid),
	.i_m1_cmd_ready (i_m1_cmd_ready),
	.o_m1_cmd_we    (o_m1_cmd_we),
	.o_m1_cmd_addr  (o_m1_cmd_addr),
	.o_m1_wdata     (o_m1_wdata),
	.o_test_done    (o_test_done),
	.o_test_fail    (o_test_fail)
);

`default_nettype wire

// File: hw/fmb_tester_top.sv
// One clock domain; qARST synchronous to iACLK; config select pin is tied low outside this block
`default_nettype none
`timescale 1ns/1ps
`include "fmb_defines.svh"

module fmb_tester_top
(
	input  logic                   iACLK,
	input  logic                   qARST,
	input  logic                   i_pll_locked,
	input  logic                   i_cfg_done,
	output logic                   o_cfg_reset,
	output logic                   o_cfg_start,
	output logic                   o_axi_rstn,
	// Memory port 0
	output logic                   o_m0_cmd_valid,
	input  logic                   i_m0_cmd_ready,
	output logic                   o_m0_cmd_we,
	output logic [`FMB_ADDR_W-1:0] o_m0_cmd_addr,
	output logic [`FMB_DATA_W-1:0] o_m0_wdata,
	input  logic                   i_m0_rvalid,
	input  logic [`FMB_DATA_W-1:0] i_m0_rdata,
	// Memory port 1
	output logic                   o_m1_cmd_valid,
	input  logic                   i_m1_cmd_ready,
	output logic                   o_m1_cmd_we,
	output logic [`FMB_ADDR_W-1:0] o_m1_cmd_addr,
	output logic [`FMB_DATA_W-1:0] o_m1_wdata,
	input  logic                   i_m1_rvalid,
	input  logic [`FMB_DATA_W-1:0] i_m1_rdata,
	// Board status
	output logic                   o_test_run,
	output logic                   o_test_done,
	output logic                   o_test_fail,
	output logic                   o_fail_chan,
	output logic [`FMB_ADDR_W-1:0] o_fail_addr,
	output logic [2:0]             o_fail_bank,
	output logic [5:0]             o_err_total
);

	// Starts both checkers together
	logic init_done;

	chk_status_if u_st0 ();
	chk_status_if u_st1 ();

	// --------------------
	// DDR config reset sequence
	ddr_reset_sequencer u_seq
	(
		.iACLK        (iACLK),
		.qARST        (qARST),
		.i_pll_locked (i_pll_locked),
		.i_cfg_done   (i_cfg_done),
		.o_cfg_reset  (o_cfg_reset),
		.o_cfg_start  (o_cfg_start),
		.o_axi_rstn   (o_axi_rstn),
		.o_init_done  (init_done)
	);

	// --------------------
	// Channel 0, bank 2 window
	memory_checker
	#(
		.P_SEED (32'h5a5a0f0f),
		.P_BASE (`FMB_CH0_BASE)
	) u_chk0
	(
		.iACLK       (iACLK),
		.qARST       (qARST),
		.i_init_done (init_done),
		.i_cmd_ready (i_m0_cmd_ready),
		.i_rvalid    (i_m0_rvalid),
		.i_rdata     (i_m0_rdata),
		.o_cmd_valid (o_m0_cmd_valid),
		.o_cmd_we    (o_m0_cmd_we),
		.o_cmd_addr  (o_m0_cmd_addr),
		.o_wdata     (o_m0_wdata),
		.o_status    (u_st0.chk)
	);

	// Channel 1, bank 5 window
	memory_checker
	#(
		.P_SEED (32'ha5a5f0f0),
		.P_BASE (`FMB_CH1_BASE)
	) u_chk1
	(
		.iACLK       (iACLK),
		.qARST       (qARST),
		.i_init_done (init_done),
		.i_cmd_ready (i_m1_cmd_ready),
		.i_rvalid    (i_m1_rvalid),
		.i_rdata     (i_m1_rdata),
		.o_cmd_valid (o_m1_cmd_valid),
		.o_cmd_we    (o_m1_cmd_we),
		.o_cmd_addr  (o_m1_cmd_addr),
		.o_wdata     (o_m1_wdata),
		.o_status    (u_st1.chk)
	);

	// --------------------
	// Board level result
	test_status_combiner u_comb
	(
		.iACLK       (iACLK),
		.qARST       (qARST),
		.i_ch0       (u_st0.mon),
		.i_ch1       (u_st1.mon),
		.o_test_run  (o_test_run),
		.o_test_done (o_test_done),
		.o_test_fail (o_test_fail),
		.o_fail_chan (o_fail_chan),
		.o_fail_addr (o_fail_addr),
		.o_fail_bank (o_fail_bank),
		.o_err_total (o_err_total)
	);

endmodule

`default_nettype wire

// File: hw/test_status_combiner.sv
// Board fail is reported only once both channels are done; location favors channel 0
`default_nettype none
`timescale 1ns/1ps
`include "fmb_defines.svh"

module test_status_combiner
(
	input  logic                   iACLK,
	input  logic                   qARST,
	chk_status_if.mon              i_ch0,
	chk_status_if.mon              i_ch1,
	output logic                   o_test_run,
	output logic                   o_test_done,
	output logic                   o_test_fail,
	output logic                   o_fail_chan,
	output logic [`FMB_ADDR_W-1:0] o_fail_addr,
	output logic [2:0]             o_fail_bank,
	output logic [5:0]             o_err_total
);

	fmb_pkg::ddr_addr_u sel_addr;
	logic               sel_chan;
	logic               both_done;

	assign both_done = i_ch0.done & i_ch1.done;

	// --------------------
	// Fault location select
	// Channel 0 first, zero when clean
	always_comb
	begin
		sel_chan      = 1'b0;
		sel_addr.flat = '0;
		if (i_ch0.fail)
			sel_addr = i_ch0.fail_addr;
		else if (i_ch1.fail)
		begin
			sel_chan = 1'b1;
			sel_addr = i_ch1.fail_addr;
		end
	end

	// --------------------
	// Board flags
	always_ff @(posedge iACLK)
	begin
		if (qARST)
		begin
			o_test_run  <= 1'b0;
			o_test_done <= 1'b0;
			o_test_fail <= 1'b0;
		end
		else
		begin
			o_test_run  <= i_ch0.run | i_ch1.run;
			o_test_done <= both_done;
			// Final verdict, so fail never leads done
			o_test_fail <= both_done & (i_ch0.fail | i_ch1.fail);
		end
	end

	// Location and totals, refreshed every cycle
	always_ff @(posedge iACLK)
	begin
		o_fail_chan <= sel_chan;
		o_fail_addr <= sel_addr.flat;
		// Bank through the field view
		o_fail_bank <= sel_addr.field.bank;
		o_err_total <= {1'b0, i_ch0.err_count} + {1'b0, i_ch1.err_count};
	end

endmodule

`default_nettype wire

// File: hw/memory_checker.sv
// Returns must come in issue order, one per read, with no back-pressure; result holds until reset
`default_nettype none
`timescale 1ns/1ps
`include "fmb_defines.svh"

module memory_checker
#(
	parameter logic [31:0]            P_SEED = 32'h5a5a0f0f,
	parameter logic [`FMB_ADDR_W-1:0] P_BASE = `FMB_CH0_BASE
)
(
	input  logic                   iACLK,
	input  logic                   qARST,
	input  logic                   i_init_done,
	input  logic                   i_cmd_ready,
	input  logic                   i_rvalid,
	input  logic [`FMB_DATA_W-1:0] i_rdata,
	output logic                   o_cmd_valid,
	output logic                   o_cmd_we,
	output logic [`FMB_ADDR_W-1:0] o_cmd_addr,
	output logic [`FMB_DATA_W-1:0] o_wdata,
	chk_status_if.chk              o_status
);

	localparam int CNT_W = $clog2(`FMB_CHK_WORDS) + 1;
	localparam int OUT_W = $clog2(`FMB_MAX_RD_INFLIGHT) + 1;
	localparam logic [CNT_W-1:0] N_WORDS   = CNT_W'(`FMB_CHK_WORDS);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`FMB_CHK_WORDS - 1);
	localparam logic [OUT_W-1:0] MAX_OUT   = OUT_W'(`FMB_MAX_RD_INFLIGHT);
	localparam logic [`FMB_ADDR_W-1:0] STEP = `FMB_ADDR_W'(`FMB_ADDR_STEP);

	fmb_pkg::chk_state_e state;
	// Issue side and return side addresses
	fmb_pkg::ddr_addr_u  iss_addr;
	fmb_pkg::ddr_addr_u  exp_addr;
	fmb_pkg::ddr_addr_u  fail_addr;
	logic [CNT_W-1:0]    iss_cnt;
	logic [CNT_W-1:0]    ret_cnt;
	logic [OUT_W-1:0]    rd_out;
	logic                fail;
	logic [4:0]          err_count;
	logic                cmd_fire;
	logic                rd_fire;
	logic                mismatch;

	// Address zero-extended, XOR seed repeated across the word
	function automatic logic [`FMB_DATA_W-1:0] f_pattern(input logic [`FMB_ADDR_W-1:0] addr);
		return {{(`FMB_DATA_W - `FMB_ADDR_W){1'b0}}, addr} ^ {(`FMB_DATA_W / 32){P_SEED}};
	endfunction

	// --------------------
	// Command channel
	// Valid drops only on transfer, so fields hold under back-pressure
	assign o_cmd_valid = (state == fmb_pkg::WRITE) ||
		((state == fmb_pkg::READ) && (iss_cnt < N_WORDS) && (rd_out < MAX_OUT));
	assign o_cmd_we    = (state == fmb_pkg::WRITE);
	assign o_cmd_addr  = iss_addr.flat;
	// Pattern on reads too, ignored by memory
	assign o_wdata     = f_pattern(iss_addr.flat);
	assign cmd_fire    = o_cmd_valid & i_cmd_ready;
	assign rd_fire     = cmd_fire & ~o_cmd_we;
	// Regenerated expected word, nothing stored
	assign mismatch    = i_rvalid & (i_rdata != f_pattern(exp_addr.flat));

	// --------------------
	// Phase FSM and issue address
	always_ff @(posedge iACLK)
	begin
		if (qARST)
		begin
			state         <= fmb_pkg::IDLE;
			iss_addr.flat <= P_BASE;
			iss_cnt       <= '0;
		end
		else
		begin
			case (state)
			fmb_pkg::IDLE:
				if (i_init_done)
					state <= fmb_pkg::WRITE;
			fmb_pkg::WRITE:
				if (cmd_fire)
				begin
					// Last write, rewind for read issue
					if (iss_cnt == LAST_WORD)
					begin
						state         <= fmb_pkg::READ;
						iss_addr.flat <= P_BASE;
						iss_cnt       <= '0;
					end
					else
					begin
						iss_addr.flat <= iss_addr.flat + STEP;
						iss_cnt       <= iss_cnt + 1'b1;
					end
				end
			fmb_pkg::READ:
			begin
				if (rd_fire)
				begin
					iss_addr.flat <= iss_addr.flat + STEP;
					iss_cnt       <= iss_cnt + 1'b1;
				end
				// Done the cycle after last return
				if (i_rvalid && (ret_cnt == LAST_WORD))
					state <= fmb_pkg::DONE;
			end
			default:
				state <= state;
			endcase
		end
	end

	// --------------------
	// Reads in flight and return compare
	always_ff @(posedge iACLK)
	begin
		if (qARST)
		begin
			rd_out        <= '0;
			exp_addr.flat <= P_BASE;
			ret_cnt       <= '0;
			fail          <= 1'b0;
			err_count     <= '0;
		end
		else
		begin
			case ({rd_fire, i_rvalid})
			2'b10:   rd_out <= rd_out + 1'b1;
			2'b01:   rd_out <= rd_out - 1'b1;
			default: rd_out <= rd_out;
			endcase
			if (i_rvalid)
			begin
				exp_addr.flat <= exp_addr.flat + STEP;
				ret_cnt       <= ret_cnt + 1'b1;
			end
			if (mismatch)
			begin
				fail <= 1'b1;
				// Saturate at 31
				if (err_count != 5'd31)
					err_count <= err_count + 1'b1;
			end
		end
	end

	// First mismatch only
	always_ff @(posedge iACLK)
	begin
		if (mismatch && !fail)
			fail_addr <= exp_addr;
	end

	// --------------------
	// Status out
	assign o_status.run       = (state == fmb_pkg::WRITE) || (state == fmb_pkg::READ);
	assign o_status.done      = (state == fmb_pkg::DONE);
	assign o_status.fail      = fail;
	assign o_status.fail_addr = fail_addr;
	assign o_status.err_count = err_count;

endmodule

`default_nettype wire

// File: hw/ddr_reset_sequencer.sv
// Assumes i_pll_locked and i_cfg_done are synchronous to iACLK; once released only qARST restarts
`default_nettype none
`timescale 1ns/1ps
`include "fmb_defines.svh"

module ddr_reset_sequencer
(
	input  logic iACLK,
	input  logic qARST,
	input  logic i_pll_locked,
	input  logic i_cfg_done,
	output logic o_cfg_reset,
	output logic o_cfg_start,
	output logic o_axi_rstn,
	output logic o_init_done
);

	// --------------------
	// States
	localparam logic [1:0] ST_CFG_RST   = 2'd0;
	localparam logic [1:0] ST_CFG_START = 2'd1;
	localparam logic [1:0] ST_RUN       = 2'd2;

	// Counter for the configuration reset pulse
	localparam int CNT_W = $clog2(`FMB_CFG_RST_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`FMB_CFG_RST_CYCLES - 1);

	logic [1:0]       state;
	logic [CNT_W-1:0] rst_cnt;

	// --------------------
	// Sequence FSM
	always_ff @(posedge iACLK)
	begin
		if (qARST)
		begin
			state   <= ST_CFG_RST;
			rst_cnt <= '0;
		end
		else
		begin
			case (state)
			ST_CFG_RST:
			begin
				// Only locked cycles count
				if (!i_pll_locked)
					rst_cnt <= '0;
				else if (rst_cnt == CNT_LAST)
				begin
					state   <= ST_CFG_START;
					rst_cnt <= '0;
				end
				else
					rst_cnt <= rst_cnt + 1'b1;
			end
			ST_CFG_START:
			begin
				// Lock lost, redo the config reset
				if (!i_pll_locked)
					state <= ST_CFG_RST;
				else if (i_cfg_done)
					state <= ST_RUN;
			end
			ST_RUN:
				// Held until reset, lock no longer matters
				state <= ST_RUN;
			default:
				state <= ST_CFG_RST;
			endcase
		end
	end

	// --------------------
	// Outputs decoded from state
	// Config reset high out of reset
	assign o_cfg_reset = (state == ST_CFG_RST);
	assign o_cfg_start = (state == ST_CFG_START);
	// Memory ports released with init done
	assign o_axi_rstn  = (state == ST_RUN);
	assign o_init_done = (state == ST_RUN);

endmodule

`default_nettype wire

// File: hw/chk_status_if.sv
// Status of one checker; fail_addr is only meaningful while fail is high
`default_nettype none
`timescale 1ns/1ps

interface chk_status_if;

	// Checker between start and last return
	logic                run;
	// Last return compared
	logic                done;
	// Sticky, set on first mismatch
	logic                fail;
	// Address of first mismatch
	fmb_pkg::ddr_addr_u  fail_addr;
	// Mismatch count, saturating
	logic [4:0]          err_count;

	// Checker side
	modport chk (output run, done, fail, fail_addr, err_count);

	// Combiner side
	modport mon (input run, done, fail, fail_addr, err_count);

endinterface

`default_nettype wire

// File: hw/fmb_pkg.sv
// Address layout follows the LPDDR4x x16 part; field widths must sum to FMB_ADDR_W
`default_nettype none
`include "fmb_defines.svh"

package fmb_pkg;

	// --------------------
	// Memory address
	// [32] chip select
	// [31:15] row, 17 bits
	// [14:12] bank
	// [11:2] column, 10 bits
	// [1:0] datapath byte lanes
	typedef struct packed
	{
		logic        cs;
		logic [16:0] row;
		logic [2:0]  bank;
		logic [9:0]  col;
		logic [1:0]  dpath;
	} ddr_addr_fields_s;

	// Same word seen flat or split into fields
	typedef union packed
	{
		logic [`FMB_ADDR_W-1:0] flat;
		ddr_addr_fields_s       field;
	} ddr_addr_u;

	// --------------------
	// Checker phase
	// DONE is terminal until reset
	typedef enum logic [2:0]
	{
		IDLE  = 3'd0,
		WRITE = 3'd1,
		READ  = 3'd2,
		DONE  = 3'd3
	} chk_state_e;

endpackage

`default_nettype wire

// File: include/fmb_defines.svh
// Widths and window are scaled for simulation; both windows must stay inside one bank
`ifndef FMB_DEFINES_SVH
`define FMB_DEFINES_SVH

// --------------------
// Datapath widths
// Data word width
`define FMB_DATA_W 64
// Address width, cs/row/bank/col/dpath layout
`define FMB_ADDR_W 33

// --------------------
// Test window
// Words written and read back per channel
`define FMB_CHK_WORDS 16
// One column step past the datapath bits
`define FMB_ADDR_STEP 4
// Channel 0 in bank 2, channel 1 in bank 5
`define FMB_CH0_BASE 33'h0_0000_2000
`define FMB_CH1_BASE 33'h0_0000_5000
// Read issue stalls at this many outstanding
`define FMB_MAX_RD_INFLIGHT 4

// --------------------
// Configuration reset pulse length, two or more cycles
`define FMB_CFG_RST_CYCLES 16

`endif
